// File: Makefile
TOP := mips_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/mips_decode.sv
`timescale 1ns/1ns

module mips_decode (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_en,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  mips_pkg::if_id_t      i_if_id,
    input  mips_pkg::wb_t         i_wb,
    input  mips_pkg::reg_addr_t   i_dbg_reg_addr,
    output mips_pkg::id_ex_t      o_id_ex,
    output logic                  o_is_halt,
    output mips_pkg::word_t       o_dbg_reg_data
);

    mips_pkg::instr_u  instr;
    mips_pkg::ctrl_t   ctrl;
    mips_pkg::word_t   regs [32];
    mips_pkg::word_t   rs_data;
    mips_pkg::word_t   rt_data;
    mips_pkg::word_t   imm_ext;
    mips_pkg::reg_addr_t wr;
    logic              bubble;

    assign instr = i_if_id.instr;

    always_comb begin
        ctrl = '0;
        case (instr.i.opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (instr.r.funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    // Unknown R-type behaves as a nop
                    default:           ctrl = '0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_HALT: ctrl.halt = 1'b1;
            default:           ctrl = '0;
        endcase
    end

    assign o_is_halt = ctrl.halt;

    // Register file reads see a same-cycle writeback
    assign rs_data = (instr.r.rs == '0) ? '0 :
                     (i_wb.we && i_wb.rd == instr.r.rs) ? i_wb.data : regs[instr.r.rs];
    assign rt_data = (instr.r.rt == '0) ? '0 :
                     (i_wb.we && i_wb.rd == instr.r.rt) ? i_wb.data : regs[instr.r.rt];

    assign o_dbg_reg_data = (i_dbg_reg_addr == '0) ? '0 : regs[i_dbg_reg_addr];

    assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign wr      = ctrl.reg_dst_rd ? instr.r.rd : instr.r.rt;

    // A held HALT keeps flowing down, a load-use stall inserts a bubble
    assign bubble = i_flush || (i_stall && !ctrl.halt);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_en && i_wb.we && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else if (i_en) begin
            if (bubble) begin
                o_id_ex <= '0;
            end else begin
                o_id_ex <= '{ctrl: ctrl, pc4: i_if_id.pc4, rs_data: rs_data,
                             rt_data: rt_data, imm: imm_ext, rs: instr.r.rs,
                             rt: instr.r.rt, wr: wr};
            end
        end
    end

endmodule

// File: rtl/mips_execute.sv
`timescale 1ns/1ns

module mips_execute (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_en,
    input  logic               i_flush,
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::fwd_sel_e i_fwd_a,
    input  mips_pkg::fwd_sel_e i_fwd_b,
    input  mips_pkg::wb_t      i_wb,
    output mips_pkg::ex_mem_t  o_ex_mem
);

    mips_pkg::word_t opnd_a;
    mips_pkg::word_t opnd_b;
    mips_pkg::word_t alu_b;
    mips_pkg::word_t alu_result;
    mips_pkg::word_t branch_target;

    function automatic mips_pkg::word_t fwd_mux(mips_pkg::fwd_sel_e sel,
                                                mips_pkg::word_t stage_val,
                                                mips_pkg::word_t exmem_val,
                                                mips_pkg::word_t wb_val);
        case (sel)
            mips_pkg::FWD_EXMEM: return exmem_val;
            mips_pkg::FWD_WB:    return wb_val;
            default:             return stage_val;
        endcase
    endfunction

    assign opnd_a = fwd_mux(i_fwd_a, i_id_ex.rs_data, o_ex_mem.alu_result, i_wb.data);
    assign opnd_b = fwd_mux(i_fwd_b, i_id_ex.rt_data, o_ex_mem.alu_result, i_wb.data);
    assign alu_b  = i_id_ex.ctrl.alu_src ? i_id_ex.imm : opnd_b;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            mips_pkg::ALU_SUB: alu_result = opnd_a - alu_b;
            mips_pkg::ALU_AND: alu_result = opnd_a & alu_b;
            mips_pkg::ALU_OR:  alu_result = opnd_a | alu_b;
            mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(opnd_a) < $signed(alu_b)};
            default:           alu_result = opnd_a + alu_b;
        endcase
    end

    // Word offset relative to the delay-free pc4
    assign branch_target = i_id_ex.pc4 + {i_id_ex.imm[29:0], 2'b00};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem <= '0;
        end else if (i_en) begin
            if (i_flush) begin
                o_ex_mem <= '0;
            end else begin
                o_ex_mem <= '{ctrl: i_id_ex.ctrl, branch_target: branch_target,
                              alu_result: alu_result, zero: (alu_result == '0),
                              store_data: opnd_b, wr: i_id_ex.wr};
            end
        end
    end

endmodule

// File: rtl/mips_fetch.sv
`timescale 1ns/1ns

module mips_fetch #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_en,
    input  logic                          i_stall,
    input  logic                          i_flush,
    input  logic                          i_branch_taken,
    input  mips_pkg::word_t               i_branch_target,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
    input  mips_pkg::word_t               i_imem_data,
    output mips_pkg::word_t               o_pc,
    output mips_pkg::if_id_t              o_if_id
);

    localparam int IA_W = $clog2(IMEM_WORDS);

    mips_pkg::word_t imem [IMEM_WORDS];
    mips_pkg::word_t pc4;
    mips_pkg::word_t fetched;

    assign pc4     = o_pc + 32'd4;
    assign fetched = imem[o_pc[IA_W+1:2]];

    // Program load port ignores the run enable
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc    <= '0;
            o_if_id <= '0;
        end else if (i_en) begin
            if (i_flush || !i_stall) begin
                o_pc <= i_branch_taken ? i_branch_target : pc4;
            end
            if (i_flush) begin
                o_if_id <= '0;
            end else if (!i_stall) begin
                o_if_id <= '{pc4: pc4, instr: fetched};
            end
        end
    end

endmodule

// File: rtl/mips_hazard.sv
`timescale 1ns/1ns

module mips_hazard (
    input  mips_pkg::if_id_t   i_if_id,
    input  logic               i_is_halt,
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::ex_mem_t  i_ex_mem,
    input  mips_pkg::wb_t      i_wb,
    input  logic               i_branch_taken,
    output logic               o_stall,
    output logic               o_flush,
    output mips_pkg::fwd_sel_e o_fwd_a,
    output mips_pkg::fwd_sel_e o_fwd_b
);

    mips_pkg::instr_u id_instr;
    logic             exmem_fwd_ok;
    logic             wb_fwd_ok;
    logic             load_use;

    assign id_instr = i_if_id.instr;

    // Register zero never forwards
    assign exmem_fwd_ok = i_ex_mem.ctrl.reg_write && i_ex_mem.wr != '0;
    assign wb_fwd_ok    = i_wb.we && i_wb.rd != '0;

    always_comb begin
        o_fwd_a = mips_pkg::FWD_IDEX;
        if (exmem_fwd_ok && i_ex_mem.wr == i_id_ex.rs) begin
            o_fwd_a = mips_pkg::FWD_EXMEM;
        end else if (wb_fwd_ok && i_wb.rd == i_id_ex.rs) begin
            o_fwd_a = mips_pkg::FWD_WB;
        end
    end

    always_comb begin
        o_fwd_b = mips_pkg::FWD_IDEX;
        if (exmem_fwd_ok && i_ex_mem.wr == i_id_ex.rt) begin
            o_fwd_b = mips_pkg::FWD_EXMEM;
        end else if (wb_fwd_ok && i_wb.rd == i_id_ex.rt) begin
            o_fwd_b = mips_pkg::FWD_WB;
        end
    end

    assign load_use = i_id_ex.ctrl.mem_read && i_id_ex.wr != '0 &&
                      (i_id_ex.wr == id_instr.r.rs || i_id_ex.wr == id_instr.r.rt);

    assign o_stall = load_use || i_is_halt;
    assign o_flush = i_branch_taken;

endmodule

// File: rtl/mips_memory.sv
`timescale 1ns/1ns

module mips_memory #(
    parameter int DMEM_WORDS = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_en,
    input  mips_pkg::ex_mem_t             i_ex_mem,
    input  logic [$clog2(DMEM_WORDS)-1:0] i_dbg_mem_addr,
    output logic                          o_branch_taken,
    output mips_pkg::word_t               o_branch_target,
    output mips_pkg::wb_t                 o_wb,
    output logic                          o_halt,
    output mips_pkg::word_t               o_dbg_mem_data
);

    localparam int DA_W = $clog2(DMEM_WORDS);

    mips_pkg::word_t   dmem [DMEM_WORDS];
    mips_pkg::word_t   load_data;
    mips_pkg::mem_wb_t mem_wb;
    logic [DA_W-1:0]   dmem_idx;

    assign o_branch_taken  = i_ex_mem.ctrl.branch &&
                             (i_ex_mem.ctrl.branch_ne ? !i_ex_mem.zero : i_ex_mem.zero);
    assign o_branch_target = i_ex_mem.branch_target;

    // Word index with the byte offset dropped
    assign dmem_idx       = i_ex_mem.alu_result[DA_W+1:2];
    assign load_data      = dmem[dmem_idx];
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_en && i_ex_mem.ctrl.mem_write) begin
            dmem[dmem_idx] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb <= '0;
        end else if (i_en) begin
            mem_wb <= '{reg_write: i_ex_mem.ctrl.reg_write,
                        mem_to_reg: i_ex_mem.ctrl.mem_to_reg,
                        halt: i_ex_mem.ctrl.halt,
                        alu_result: i_ex_mem.alu_result,
                        load_data: load_data,
                        wr: i_ex_mem.wr};
        end
    end

    always_comb begin
        o_wb = '{we: mem_wb.reg_write, rd: mem_wb.wr,
                 data: mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result};
    end

    // Stays high once set since the core enable drops with it
    assign o_halt = mem_wb.halt;

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 5;
    localparam int IMM_W  = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [IMM_W-1:0]  imm_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B,
        OP_HALT    = 6'h3F
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Forwarding source for an EX operand
    typedef enum logic [1:0] {
        FWD_IDEX,
        FWD_EXMEM,
        FWD_WB
    } fwd_sel_e;

    typedef union packed {
        struct packed {
            opcode_e   opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            reg_addr_t rd;
            logic [4:0] shamt;
            funct_e    funct;
        } r;
        struct packed {
            opcode_e   opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            imm_t      imm;
        } i;
    } instr_u;

    // All zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    alu_src;
        logic    reg_dst_rd;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t wr;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     branch_target;
        word_t     alu_result;
        logic      zero;
        word_t     store_data;
        reg_addr_t wr;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      halt;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t wr;
    } mem_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

// File: rtl/mips_top.sv
`timescale 1ns/1ns

module mips_top #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_run,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
    input  mips_pkg::word_t               i_imem_data,
    input  mips_pkg::reg_addr_t           i_dbg_reg_addr,
    input  logic [$clog2(DMEM_WORDS)-1:0] i_dbg_mem_addr,
    output mips_pkg::word_t               o_pc,
    output mips_pkg::word_t               o_dbg_reg_data,
    output mips_pkg::word_t               o_dbg_mem_data,
    output logic                          o_halt
);

    mips_pkg::if_id_t   if_id;
    mips_pkg::id_ex_t   id_ex;
    mips_pkg::ex_mem_t  ex_mem;
    mips_pkg::wb_t      wb;
    mips_pkg::fwd_sel_e fwd_a;
    mips_pkg::fwd_sel_e fwd_b;
    mips_pkg::word_t    branch_target;
    logic               branch_taken;
    logic               stall;
    logic               flush;
    logic               is_halt;
    logic               en;

    // Whole core freezes when not running or once halted
    assign en = i_run && !o_halt;

    mips_fetch #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_en            (en),
        .i_stall         (stall),
        .i_flush         (flush),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_pc            (o_pc),
        .o_if_id         (if_id)
    );

    mips_decode u_decode (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_en           (en),
        .i_stall        (stall),
        .i_flush        (flush),
        .i_if_id        (if_id),
        .i_wb           (wb),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_id_ex        (id_ex),
        .o_is_halt      (is_halt),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    mips_hazard u_hazard (
        .i_if_id        (if_id),
        .i_is_halt      (is_halt),
        .i_id_ex        (id_ex),
        .i_ex_mem       (ex_mem),
        .i_wb           (wb),
        .i_branch_taken (branch_taken),
        .o_stall        (stall),
        .o_flush        (flush),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b)
    );

    mips_execute u_execute (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_en     (en),
        .i_flush  (flush),
        .i_id_ex  (id_ex),
        .i_fwd_a  (fwd_a),
        .i_fwd_b  (fwd_b),
        .i_wb     (wb),
        .o_ex_mem (ex_mem)
    );

    mips_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_en            (en),
        .i_ex_mem        (ex_mem),
        .i_dbg_mem_addr  (i_dbg_mem_addr),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_wb            (wb),
        .o_halt          (o_halt),
        .o_dbg_mem_data  (o_dbg_mem_data)
    );

endmodule

// File: tb.f
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_hazard.sv
rtl/mips_execute.sv
rtl/mips_memory.sv
rtl/mips_top.sv
tb/tb_clock.sv
tb/mips_tb.sv

// File: tb/mips_tb.sv
`timescale 1ns/1ns

module mips_tb;

    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 16;
    localparam int IA_W         = $clog2(IMEM_WORDS);
    localparam int DA_W         = $clog2(DMEM_WORDS);
    localparam int CLK_NS       = 10;
    localparam int NUM_PROGRAMS = 16;
    localparam int BODY_MAX     = 32;
    localparam int HALT_LIMIT   = 4 * (BODY_MAX + 1) + 16;
    localparam int WATCHDOG_NS  = (NUM_PROGRAMS * (4 * IMEM_WORDS + 50) + 3) * CLK_NS;

    logic                clk;
    logic                clk_rst_n;
    logic                soft_rst_n;
    logic                arst_n;
    logic                run;
    logic                imem_we;
    logic [IA_W-1:0]     imem_addr;
    mips_pkg::word_t     imem_data;
    mips_pkg::reg_addr_t dbg_reg_addr;
    logic [DA_W-1:0]     dbg_mem_addr;
    mips_pkg::word_t     pc;
    mips_pkg::word_t     dbg_reg_data;
    mips_pkg::word_t     dbg_mem_data;
    logic                halt;

    mips_pkg::word_t prog [IMEM_WORDS];
    int              prog_len;
    mips_pkg::word_t model_regs [32];
    mips_pkg::word_t model_mem [DMEM_WORDS];
    logic [31:0]     lfsr_state;
    int              mismatch_count;
    int              fail_count;

    assign arst_n = clk_rst_n & soft_rst_n;

    tb_clock #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (3)
    ) u_clock (
        .o_clk   (clk),
        .o_rst_n (clk_rst_n)
    );

    mips_top #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_run          (run),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_pc           (pc),
        .o_dbg_reg_data (dbg_reg_data),
        .o_dbg_mem_data (dbg_mem_data),
        .o_halt         (halt)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic bit coin();
        return take_bits(1) == 1;
    endfunction

    function automatic mips_pkg::reg_addr_t pick_reg();
        return 5'(1 + take_bits(3) % 7);
    endfunction

    function automatic mips_pkg::funct_e pick_funct(input int unsigned v);
        case (v % 5)
            0:       return mips_pkg::FN_ADDU;
            1:       return mips_pkg::FN_SUBU;
            2:       return mips_pkg::FN_AND;
            3:       return mips_pkg::FN_OR;
            default: return mips_pkg::FN_SLT;
        endcase
    endfunction

    function automatic mips_pkg::word_t enc_r(input mips_pkg::funct_e f,
                                              input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rt,
                                              input mips_pkg::reg_addr_t rd);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_e op,
                                              input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rt,
                                              input mips_pkg::imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // Kind 0 ALU only, 1 adds LW/SW, 2 and 3 add BEQ/BNE
    task automatic build_program(input int kind);
        int                  body_len;
        int                  max_off;
        int                  off;
        int unsigned         sel;
        mips_pkg::reg_addr_t rd;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t last_dst;
        mips_pkg::imm_t      imm;
        logic [3:0]          imm4;
        body_len = 8 + int'(take_bits(5) % 25);
        last_dst = 5'd1;
        for (int i = 0; i < body_len; i++) begin
            sel = take_bits(3);
            rd  = pick_reg();
            rs  = coin() ? last_dst : pick_reg();
            rt  = coin() ? last_dst : pick_reg();
            if (kind >= 2 && sel >= 6) begin
                // Target may be the HALT but never beyond it
                max_off = body_len - 1 - i;
                off = int'(take_bits(2));
                if (off > max_off) begin
                    off = max_off;
                end
                if (take_bits(2) == 0) begin
                    rt = rs;
                end
                prog[i] = enc_i(coin() ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ, rs, rt, 16'(off));
            end else if (kind >= 1 && sel >= 4) begin
                imm = 16'(take_bits(DA_W) * 4);
                if (coin()) begin
                    prog[i]  = enc_i(mips_pkg::OP_LW, 5'd0, rd, imm);
                    last_dst = rd;
                end else begin
                    prog[i] = enc_i(mips_pkg::OP_SW, 5'd0, rt, imm);
                end
            end else if (coin()) begin
                imm4     = 4'(take_bits(4));
                prog[i]  = enc_i(mips_pkg::OP_ADDIU, rs, rd, {{12{imm4[3]}}, imm4});
                last_dst = rd;
            end else begin
                prog[i]  = enc_r(pick_funct(take_bits(3)), rs, rt, rd);
                last_dst = rd;
            end
        end
        prog[body_len] = {mips_pkg::OP_HALT, 26'd0};
        prog_len = body_len + 1;
    endtask

    // One instruction at a time with no pipeline
    task automatic run_model();
        mips_pkg::instr_u ins;
        mips_pkg::word_t  a;
        mips_pkg::word_t  b;
        mips_pkg::word_t  imm;
        mips_pkg::word_t  addr;
        int               pc_idx;
        bit               done;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            model_mem[m] = '0;
        end
        pc_idx = 0;
        done   = 1'b0;
        while (!done && pc_idx < prog_len) begin
            ins  = prog[pc_idx];
            a    = model_regs[ins.r.rs];
            b    = model_regs[ins.r.rt];
            imm  = {{16{ins.i.imm[15]}}, ins.i.imm};
            addr = a + imm;
            pc_idx++;
            case (ins.i.opcode)
                mips_pkg::OP_SPECIAL: begin
                    case (ins.r.funct)
                        mips_pkg::FN_ADDU: model_regs[ins.r.rd] = a + b;
                        mips_pkg::FN_SUBU: model_regs[ins.r.rd] = a - b;
                        mips_pkg::FN_AND:  model_regs[ins.r.rd] = a & b;
                        mips_pkg::FN_OR:   model_regs[ins.r.rd] = a | b;
                        mips_pkg::FN_SLT:
                            model_regs[ins.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                mips_pkg::OP_ADDIU: model_regs[ins.i.rt] = addr;
                mips_pkg::OP_LW:    model_regs[ins.i.rt] = model_mem[addr[DA_W+1:2]];
                mips_pkg::OP_SW:    model_mem[addr[DA_W+1:2]] = b;
                mips_pkg::OP_BEQ: begin
                    if (a == b) begin
                        pc_idx += int'(imm);
                    end
                end
                mips_pkg::OP_BNE: begin
                    if (a != b) begin
                        pc_idx += int'(imm);
                    end
                end
                mips_pkg::OP_HALT: done = 1'b1;
                default: ;
            endcase
            model_regs[0] = '0;
        end
    endtask

    task automatic check_word(input mips_pkg::word_t actual, input mips_pkg::word_t expected,
                              input string name);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic print_counts();
        $display("%0d mismatches, %0d other failures", mismatch_count, fail_count);
    endtask

    task automatic apply_reset();
        run        = 1'b0;
        soft_rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        soft_rst_n = 1'b1;
    endtask

    // Debug reads end just after a clock edge
    task automatic check_state(input bit use_model);
        mips_pkg::word_t expected;
        for (int r = 0; r < 32; r++) begin
            dbg_reg_addr = r[4:0];
            #1;
            expected = use_model ? model_regs[r] : '0;
            check_word(dbg_reg_data, expected, $sformatf("r%0d", r));
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            dbg_mem_addr = m[DA_W-1:0];
            #1;
            expected = use_model ? model_mem[m] : '0;
            check_word(dbg_mem_data, expected, $sformatf("dmem[%0d]", m));
        end
        @(posedge clk);
        #1;
    endtask

    // Unused words get a HALT carrying their address
    task automatic load_program();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem_we   = 1'b1;
            imem_addr = a[IA_W-1:0];
            imem_data = (a < prog_len) ? prog[a] : {mips_pkg::OP_HALT, 26'(a)};
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        check_word(pc, '0, "o_pc");
    endtask

    task automatic run_until_halt(input bit with_gaps);
        int              cycles;
        int              spans_left;
        int              gap_len;
        mips_pkg::word_t held_pc;
        cycles     = 0;
        spans_left = with_gaps ? 4 : 0;
        run        = 1'b1;
        while (!halt && cycles < HALT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!halt && spans_left > 0 && take_bits(3) == 0) begin
                spans_left--;
                gap_len = 1 + int'(take_bits(3));
                held_pc = pc;
                run     = 1'b0;
                repeat (gap_len) begin
                    @(posedge clk);
                    #1;
                    check_word(pc, held_pc, "o_pc");
                end
                check_bit(halt, 1'b0, "o_halt");
                run = 1'b1;
            end
        end
        if (!halt) begin
            fail_count++;
            $display("error at %0t: o_halt did not rise within %0d cycles of the program start",
                     $time, HALT_LIMIT);
        end
    endtask

    task automatic hold_after_halt();
        mips_pkg::word_t held_pc;
        held_pc = pc;
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit(halt, 1'b1, "o_halt");
            check_word(pc, held_pc, "o_pc");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_count++;
        $display("error at %0t: watchdog expired before all programs finished", $time);
        print_counts();
        $display("Test FAILED");
        $finish;
    end

    initial begin
        run            = 1'b0;
        soft_rst_n     = 1'b1;
        imem_we        = 1'b0;
        imem_addr      = '0;
        imem_data      = '0;
        dbg_reg_addr   = '0;
        dbg_mem_addr   = '0;
        lfsr_state     = 32'ha5bdd215;
        mismatch_count = 0;
        fail_count     = 0;
        prog_len       = 0;
        wait (clk_rst_n == 1'b1);
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            build_program(p % 4);
            run_model();
            apply_reset();
            check_word(pc, '0, "o_pc");
            check_bit(halt, 1'b0, "o_halt");
            check_state(1'b0);
            load_program();
            run_until_halt(p % 4 == 3);
            if (halt) begin
                hold_after_halt();
            end
            check_state(1'b1);
        end
        print_counts();
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release lands just after a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule
